// ==== design/evr_settings.svh ====
// comma and special event codes, alignment count, marker stretch lengths, monitor FIFO depth
`ifndef EVR_SETTINGS_SVH
`define EVR_SETTINGS_SVH

////////////////////////////////////////////////////////////
// link alignment

// K28.5 comma, low byte of the rx word
`define EVR_COMMA_CODE 8'hBC

// commas in a row before the link counts as aligned
`define EVR_COMMAS_NEEDED 60

////////////////////////////////////////////////////////////
// special event codes

`define EVR_HEARTBEAT_CODE 8'd122 // heartbeat from the event generator
`define EVR_PPS_CODE       8'd125 // pulse per second, steps the seconds

////////////////////////////////////////////////////////////
// markers and monitor

// heartbeat marker length, short so a simulation can see whole pulses
`define EVR_HB_STRETCH_CYCLES 24

`define EVR_PPS_STRETCH_CYCLES 6 // pps marker length

`define EVR_MON_DEPTH 8 // monitor FIFO entries

`endif

// ==== design/evrPkg.sv ====
// event code, timestamp and monitor entry types
package evrPkg;

    ////////////////////////////////////////////////////////////
    // link side

    // one decoded event code, 0 means no event
    typedef logic [7:0] evrCode_t;

    ////////////////////////////////////////////////////////////
    // time base

    // seconds in the upper word, ticks of evrClk in the lower
    typedef struct packed {
        logic [31:0] seconds; // counts pps codes
        logic [31:0] ticks;   // cleared on each pps
    } evrTimestamp_t;

    ////////////////////////////////////////////////////////////
    // monitor FIFO word

    // 72 bits, code in the low byte
    typedef struct packed {
        evrTimestamp_t timestamp; // time the code was seen
        evrCode_t      code;      // the recorded event code
    } monEntry_t;

endpackage

// ==== design/evrLinkAlign.sv ====
// comma counting, link alignment flag and good event code extraction
`timescale 1ns/1ns
`include "evr_settings.svh"

module evrLinkAlign (
    input  logic              evrClk,
    input  logic              rstN_i,
    input  logic [15:0]       rxData_i,       // decoded 8b/10b word
    input  logic [1:0]        rxIsK_i,        // K flag per byte
    input  logic [1:0]        rxNotInTable_i, // decode error per byte
    output logic              linkAligned_o,
    output evrPkg::evrCode_t  evrCode_o,
    output logic              evrCodeValid_o
);

    ////////////////////////////////////////////////////////////
    // comma counter

    // counts down through zero, top bit set means aligned
    localparam int COMMA_RELOAD = `EVR_COMMAS_NEEDED - 1;
    localparam int COMMA_CNT_W  = $clog2(COMMA_RELOAD + 1) + 1;

    logic [COMMA_CNT_W-1:0] commaCnt;
    logic                   rxError;   // word cannot be trusted
    logic                   rxComma;   // K28.5 in the low byte
    logic                   goodCode;  // event code worth passing on

    assign rxError = (rxNotInTable_i != 2'b00) || rxIsK_i[1];
    assign rxComma = rxIsK_i[0] && (rxData_i[7:0] == `EVR_COMMA_CODE);

    always_ff @(posedge evrClk or negedge rstN_i) begin
        if (!rstN_i) begin
            commaCnt <= COMMA_CNT_W'(COMMA_RELOAD);
        end else if (rxError) begin
            commaCnt <= COMMA_CNT_W'(COMMA_RELOAD); // start over
        end else if (!linkAligned_o && rxComma) begin
            commaCnt <= commaCnt - 1'b1;
        end
    end

    assign linkAligned_o = commaCnt[COMMA_CNT_W-1]; // holds once reached

    ////////////////////////////////////////////////////////////
    // event code register

    // nonzero data byte while aligned
    assign goodCode = linkAligned_o && (rxData_i[7:0] != 8'h00) && !rxIsK_i[0];

    always_ff @(posedge evrClk or negedge rstN_i) begin
        if (!rstN_i) begin
            evrCode_o      <= '0;
            evrCodeValid_o <= 1'b0;
        end else begin
            evrCode_o      <= goodCode ? rxData_i[7:0] : 8'h00;
            evrCodeValid_o <= goodCode;
        end
    end

    // a valid code is never zero and only comes from an aligned link
    assert property (@(posedge evrClk) disable iff (!rstN_i)
        evrCodeValid_o |-> (evrCode_o != 8'h00) && $past(linkAligned_o))
        else $error("event code valid without alignment or with zero code");

endmodule

// ==== design/evrTimeBase.sv ====
// local seconds and ticks counter stepped by the pps event code
`timescale 1ns/1ns
`include "evr_settings.svh"

module evrTimeBase (
    input  logic                  evrClk,
    input  logic                  rstN_i,
    input  evrPkg::evrCode_t      evrCode_i,
    input  logic                  evrCodeValid_i,
    output evrPkg::evrTimestamp_t timestamp_o
);

    logic [31:0] seconds; // pps count since reset
    logic [31:0] ticks;   // evrClk cycles since last pps
    logic        ppsSeen;

    // pps code valid this cycle
    assign ppsSeen = evrCodeValid_i && (evrCode_i == `EVR_PPS_CODE);

    ////////////////////////////////////////////////////////////
    // counters

    always_ff @(posedge evrClk or negedge rstN_i) begin
        if (!rstN_i) begin
            seconds <= '0;
            ticks   <= '0;
        end else if (ppsSeen) begin
            // new second visible in the cycle after the code
            seconds <= seconds + 32'd1;
            ticks   <= '0;
        end else begin
            ticks <= ticks + 32'd1; // free running, wraps
        end
    end

    // straight from the registers, no extra stage
    assign timestamp_o.seconds = seconds;
    assign timestamp_o.ticks   = ticks;

endmodule

// ==== design/eventMonitorFifo.sv ====
// event monitor code-select table and first-word-fall-through FIFO of timestamped codes
`timescale 1ns/1ns
`include "evr_settings.svh"

module eventMonitorFifo (
    input  logic                  evrClk,
    input  logic                  rstN_i,
    input  evrPkg::evrCode_t      evrCode_i,
    input  logic                  evrCodeValid_i,
    input  evrPkg::evrTimestamp_t timestamp_i,
    input  logic                  monSelWe_i,   // table write strobe
    input  evrPkg::evrCode_t      monSelCode_i, // table address
    input  logic                  monSelOn_i,   // record this code or not
    input  logic                  monReadEn_i,  // pop strobe
    output evrPkg::monEntry_t     monEntry_o,   // head entry
    output logic                  monEmpty_o,
    output logic                  monOverflow_o // sticky
);

    localparam int DEPTH = `EVR_MON_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [255:0]      selTable; // one bit per event code
    logic              writeReq; // staged entry is selected
    evrPkg::monEntry_t entryD;   // code and time, one stage late
    evrPkg::monEntry_t mem [DEPTH];
    logic [PTR_W-1:0]  wrPtr;
    logic [PTR_W-1:0]  rdPtr;
    logic [CNT_W-1:0]  fillCount;
    logic              full;
    logic              doWrite;
    logic              doRead;

    ////////////////////////////////////////////////////////////
    // select table and entry stage

    always_ff @(posedge evrClk or negedge rstN_i) begin
        if (!rstN_i) begin
            selTable <= '0; // nothing recorded
            writeReq <= 1'b0;
        end else begin
            if (monSelWe_i) selTable[monSelCode_i] <= monSelOn_i;
            writeReq <= evrCodeValid_i && selTable[evrCode_i];
        end
    end

    always_ff @(posedge evrClk) begin
        entryD.code      <= evrCode_i;
        entryD.timestamp <= timestamp_i; // time the code was at the output
    end

    ////////////////////////////////////////////////////////////
    // circular buffer

    assign full    = (fillCount == CNT_W'(DEPTH));
    assign doWrite = writeReq && !full;      // full drops the entry
    assign doRead  = monReadEn_i && !monEmpty_o;

    always_ff @(posedge evrClk) begin
        if (doWrite) mem[wrPtr] <= entryD;
    end

    always_ff @(posedge evrClk or negedge rstN_i) begin
        if (!rstN_i) begin
            wrPtr         <= '0;
            rdPtr         <= '0;
            fillCount     <= '0;
            monOverflow_o <= 1'b0;
        end else begin
            if (doWrite) wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            if (doRead) rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            if (doWrite && !doRead) fillCount <= fillCount + 1'b1;
            else if (doRead && !doWrite) fillCount <= fillCount - 1'b1;
            if (writeReq && full) monOverflow_o <= 1'b1; // lost an entry
        end
    end

    assign monEmpty_o = (fillCount == '0);
    assign monEntry_o = mem[rdPtr]; // head falls through

    assert property (@(posedge evrClk) disable iff (!rstN_i)
        fillCount <= CNT_W'(DEPTH))
        else $error("monitor fill count above depth");

    // pop on empty is dropped, but the reader is out of step
    assert property (@(posedge evrClk) disable iff (!rstN_i)
        monReadEn_i |-> !monEmpty_o)
        else $warning("monitor pop while empty");

endmodule

// ==== design/evrMarkerStretch.sv ====
// retriggerable pulse stretcher for one special event code
`timescale 1ns/1ns
`include "evr_settings.svh"

module evrMarkerStretch #(
    parameter evrPkg::evrCode_t MARK_CODE      = `EVR_HEARTBEAT_CODE,
    parameter int               STRETCH_CYCLES = `EVR_HB_STRETCH_CYCLES
) (
    input  logic             evrClk,
    input  logic             rstN_i,
    input  evrPkg::evrCode_t evrCode_i,
    input  logic             evrCodeValid_i,
    output logic             marker_o
);

    localparam int CNT_W = $clog2(STRETCH_CYCLES + 1);

    logic [CNT_W-1:0] stretchCnt; // cycles of marker left
    logic             hit;        // our code this cycle

    assign hit = evrCodeValid_i && (evrCode_i == MARK_CODE);

    always_ff @(posedge evrClk or negedge rstN_i) begin
        if (!rstN_i) begin
            stretchCnt <= '0;
        end else if (hit) begin
            stretchCnt <= CNT_W'(STRETCH_CYCLES); // restart on repeat
        end else if (stretchCnt != '0) begin
            stretchCnt <= stretchCnt - 1'b1;
        end
    end

    assign marker_o = (stretchCnt != '0);

endmodule

// ==== design/evrTop.sv ====
// receiver top level with link alignment, time base, event monitor and two markers
`timescale 1ns/1ns
`include "evr_settings.svh"

module evrTop (
    input  logic              evrClk,
    input  logic              rstN_i,
    input  logic [15:0]       rxData_i,
    input  logic [1:0]        rxIsK_i,
    input  logic [1:0]        rxNotInTable_i,
    input  logic              monSelWe_i,
    input  evrPkg::evrCode_t  monSelCode_i,
    input  logic              monSelOn_i,
    input  logic              monReadEn_i,
    output logic              linkAligned_o,
    output evrPkg::evrCode_t  evrCode_o,
    output logic              evrCodeValid_o,
    output evrPkg::monEntry_t monEntry_o,
    output logic              monEmpty_o,
    output logic              monOverflow_o,
    output logic              heartbeatMarker_o,
    output logic              ppsMarker_o
);

    evrPkg::evrTimestamp_t timestamp; // local time for the monitor

    ////////////////////////////////////////////////////////////
    // link and time

    evrLinkAlign linkAlign (
        .evrClk         (evrClk),
        .rstN_i         (rstN_i),
        .rxData_i       (rxData_i),
        .rxIsK_i        (rxIsK_i),
        .rxNotInTable_i (rxNotInTable_i),
        .linkAligned_o  (linkAligned_o),
        .evrCode_o      (evrCode_o),
        .evrCodeValid_o (evrCodeValid_o)
    );

    evrTimeBase timeBase (
        .evrClk         (evrClk),
        .rstN_i         (rstN_i),
        .evrCode_i      (evrCode_o),
        .evrCodeValid_i (evrCodeValid_o),
        .timestamp_o    (timestamp)
    );

    ////////////////////////////////////////////////////////////
    // monitor and markers

    eventMonitorFifo monitor (
        .evrClk         (evrClk),
        .rstN_i         (rstN_i),
        .evrCode_i      (evrCode_o),
        .evrCodeValid_i (evrCodeValid_o),
        .timestamp_i    (timestamp),
        .monSelWe_i     (monSelWe_i),
        .monSelCode_i   (monSelCode_i),
        .monSelOn_i     (monSelOn_i),
        .monReadEn_i    (monReadEn_i),
        .monEntry_o     (monEntry_o),
        .monEmpty_o     (monEmpty_o),
        .monOverflow_o  (monOverflow_o)
    );

    evrMarkerStretch #(
        .MARK_CODE      (`EVR_HEARTBEAT_CODE),
        .STRETCH_CYCLES (`EVR_HB_STRETCH_CYCLES)
    ) heartbeatStretch (
        .evrClk         (evrClk),
        .rstN_i         (rstN_i),
        .evrCode_i      (evrCode_o),
        .evrCodeValid_i (evrCodeValid_o),
        .marker_o       (heartbeatMarker_o)
    );

    evrMarkerStretch #(
        .MARK_CODE      (`EVR_PPS_CODE),
        .STRETCH_CYCLES (`EVR_PPS_STRETCH_CYCLES)
    ) ppsStretch (
        .evrClk         (evrClk),
        .rstN_i         (rstN_i),
        .evrCode_i      (evrCode_o),
        .evrCodeValid_i (evrCodeValid_o),
        .marker_o       (ppsMarker_o)
    );

endmodule

// ==== sim/evrClockGen.sv ====
// testbench clock and power-on reset generator
`timescale 1ns/1ns

module evrClockGen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic evrClk_o,
    output logic rstN_o
);

    initial begin
        evrClk_o = 1'b0;
        forever #(PERIOD_NS / 2) evrClk_o = ~evrClk_o;
    end

    // reset held low from time 0
    initial begin
        rstN_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge evrClk_o);
        @(negedge evrClk_o);
        rstN_o = 1'b1; // release half a cycle away from the active edge
    end

endmodule

// ==== sim/evrTop_tb.sv ====
// testbench top with trace reader, stimulus, compare tasks, watchdog and report
`timescale 1ns/1ns
`include "evr_settings.svh"

module evrTop_tb;

    localparam int SEED     = 32'h0e89ed66;
    localparam int MAX_IDLE = 3; // 0 to 2 idle words before a record

    logic              evrClk;
    logic              rstN;
    logic [15:0]       rxData;
    logic [1:0]        rxIsK;
    logic [1:0]        rxNotInTable;
    logic              monSelWe;
    evrPkg::evrCode_t  monSelCode;
    logic              monSelOn;
    logic              monReadEn;
    logic              linkAligned;
    evrPkg::evrCode_t  evrCode;
    logic              evrCodeValid;
    evrPkg::monEntry_t monEntry;
    logic              monEmpty;
    logic              monOverflow;
    logic              heartbeatMarker;
    logic              ppsMarker;

    int           cycleCnt;     // edges since reset release
    int           traceCycles;  // cycle budget from the trace header
    int           idleCycles;   // random idles inserted so far
    int           lastStamp;    // cycleCnt seen at the latest drive edge
    int           tickBase;     // expected ticks = stamp - tickBase
    int           errors;
    int           checks;
    int           tests;
    int           testErrors;
    string        testName;
    logic [255:0] shadowSel;    // select table as written by the trace
    logic [31:0]  expTicksQ[$]; // expected ticks of each recorded entry

    evrClockGen clockGen (
        .evrClk_o (evrClk),
        .rstN_o   (rstN)
    );

    evrTop evrTop_i (
        .evrClk            (evrClk),
        .rstN_i            (rstN),
        .rxData_i          (rxData),
        .rxIsK_i           (rxIsK),
        .rxNotInTable_i    (rxNotInTable),
        .monSelWe_i        (monSelWe),
        .monSelCode_i      (monSelCode),
        .monSelOn_i        (monSelOn),
        .monReadEn_i       (monReadEn),
        .linkAligned_o     (linkAligned),
        .evrCode_o         (evrCode),
        .evrCodeValid_o    (evrCodeValid),
        .monEntry_o        (monEntry),
        .monEmpty_o        (monEmpty),
        .monOverflow_o     (monOverflow),
        .heartbeatMarker_o (heartbeatMarker),
        .ppsMarker_o       (ppsMarker)
    );

    always_ff @(posedge evrClk or negedge rstN) begin
        if (!rstN) cycleCnt <= 0;
        else cycleCnt <= cycleCnt + 1; // same count as the DUT ticks before any pps
    end

    ////////////////////////////////////////////////////////////
    // compare tasks

    task automatic noteError();
        errors++;
        testErrors++;
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            noteError();
            $display("[ERROR] %0t ns %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic checkCode(input string name, input evrPkg::evrCode_t got,
                             input evrPkg::evrCode_t exp);
        checks++;
        if (got !== exp) begin
            noteError();
            $display("[ERROR] %0t ns %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            noteError();
            $display("[ERROR] %0t ns %s high for %0d cycles expected %0d",
                     $time, name, got, exp);
        end
    endtask

    task automatic checkEntry(input evrPkg::monEntry_t got, input evrPkg::monEntry_t exp);
        string gotText;
        string expText;
        checks++;
        if (got !== exp) begin
            noteError();
            gotText = $sformatf("code %0d sec %0d ticks %0d", got.code,
                                got.timestamp.seconds, got.timestamp.ticks);
            expText = $sformatf("code %0d sec %0d ticks %0d", exp.code,
                                exp.timestamp.seconds, exp.timestamp.ticks);
            $display("[ERROR] %0t ns monEntry_o got %s expected %s",
                     $time, gotText, expText);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus

    // sets every DUT input on one rising edge
    task automatic drive(input logic [15:0] data, input logic [1:0] isK,
                         input logic [1:0] nit, input logic we,
                         input evrPkg::evrCode_t selCode, input logic selOn,
                         input logic rd);
        @(posedge evrClk);
        lastStamp = cycleCnt;
        rxData       <= data;
        rxIsK        <= isK;
        rxNotInTable <= nit;
        monSelWe     <= we;
        monSelCode   <= selCode;
        monSelOn     <= selOn;
        monReadEn    <= rd;
    endtask

    task automatic idle(input int n);
        repeat (n) drive(16'h0000, 2'b00, 2'b00, 1'b0, 8'h00, 1'b0, 1'b0);
    endtask

    task automatic randomIdles();
        int n;
        n = $urandom % MAX_IDLE;
        idleCycles += n;
        idle(n);
    endtask

    // data word and a check of the registered code one edge later
    task automatic sendCode(input evrPkg::evrCode_t code, input logic valid);
        drive({8'h00, code}, 2'b00, 2'b00, 1'b0, 8'h00, 1'b0, 1'b0);
        if (valid && shadowSel[code] && expTicksQ.size() < `EVR_MON_DEPTH)
            expTicksQ.push_back(32'(lastStamp - tickBase)); // full FIFO drops it
        if (valid && code == `EVR_PPS_CODE)
            tickBase = lastStamp + 1; // ticks restart after this pps
        idle(1);
        @(negedge evrClk);
        checkBit("evrCodeValid_o", evrCodeValid, valid);
        checkCode("evrCode_o", evrCode, valid ? code : 8'h00);
    endtask

    task automatic popCheck(input evrPkg::evrCode_t code, input logic [31:0] sec);
        evrPkg::monEntry_t exp;
        int                waited;
        waited = 0;
        @(negedge evrClk);
        while (monEmpty && waited < 16) begin // entry may still be in flight
            @(negedge evrClk);
            waited++;
        end
        if (monEmpty || expTicksQ.size() == 0) begin
            noteError();
            $display("test %s: no monitor entry to pop at %0t ns", testName, $time);
        end else begin
            exp.code              = code;
            exp.timestamp.seconds = sec;
            exp.timestamp.ticks   = expTicksQ.pop_front();
            checkEntry(monEntry, exp);
            drive(16'h0000, 2'b00, 2'b00, 1'b0, 8'h00, 1'b0, 1'b1);
            idle(1);
        end
    endtask

    // a gap above zero sends the code twice and times the pulse from the second
    task automatic markerPulse(input evrPkg::evrCode_t code, input int gap, input int len);
        bit    isPps;
        string name;
        int    count;
        isPps = (code == `EVR_PPS_CODE);
        name  = isPps ? "ppsMarker_o" : "heartbeatMarker_o";
        count = 0;
        if (gap > 0) begin
            sendCode(code, 1'b1);
            idle(gap);
        end
        sendCode(code, 1'b1);
        if (gap == 0) checkBit(name, isPps ? ppsMarker : heartbeatMarker, 1'b0);
        for (int n = 0; n < len + 4; n++) begin
            idle(1);
            @(negedge evrClk);
            if (!(isPps ? ppsMarker : heartbeatMarker)) break;
            count++;
        end
        checkCount(name, count, len);
    endtask

    ////////////////////////////////////////////////////////////
    // trace reader

    task automatic closeTest();
        if (testName != "") begin
            if (testErrors == 0) $display("test %s: ok", testName);
            else $display("test %s: %0d errors", testName, testErrors);
        end
        testErrors = 0;
        testName   = "";
    endtask

    task automatic runRecords(input int fd);
        string op;
        string line;
        int    a;
        int    b;
        int    c;
        bit    done;
        done = 1'b0;
        wait (rstN === 1'b1);
        while (!done && $fscanf(fd, "%s", op) == 1) begin
            if (op == "#") begin
                void'($fgets(line, fd)); // column notes
            end else if (op == "L") begin
                void'($fscanf(fd, "%d", traceCycles));
            end else if (op == "T") begin
                closeTest();
                void'($fscanf(fd, "%s", testName));
                tests++;
            end else if (op == "X") begin
                done = 1'b1;
            end else begin
                randomIdles();
                case (op)
                    "R": begin
                        @(negedge evrClk);
                        checkBit("linkAligned_o", linkAligned, 1'b0);
                        checkBit("evrCodeValid_o", evrCodeValid, 1'b0);
                        checkBit("heartbeatMarker_o", heartbeatMarker, 1'b0);
                        checkBit("ppsMarker_o", ppsMarker, 1'b0);
                        checkBit("monOverflow_o", monOverflow, 1'b0);
                        checkBit("monEmpty_o", monEmpty, 1'b1);
                    end
                    "C": begin
                        void'($fscanf(fd, "%d", a));
                        repeat (a) drive({8'h00, `EVR_COMMA_CODE}, 2'b01, 2'b00,
                                         1'b0, 8'h00, 1'b0, 1'b0);
                    end
                    "A": begin
                        void'($fscanf(fd, "%d", a));
                        idle(1);
                        @(negedge evrClk);
                        checkBit("linkAligned_o", linkAligned, a[0]);
                    end
                    "N": drive(16'h0000, 2'b00, 2'b01, 1'b0, 8'h00, 1'b0, 1'b0);
                    "K": begin
                        void'($fscanf(fd, "%d", a));
                        drive({8'h00, a[7:0]}, 2'b01, 2'b00, 1'b0, 8'h00, 1'b0, 1'b0);
                        idle(1);
                        @(negedge evrClk);
                        checkBit("evrCodeValid_o", evrCodeValid, 1'b0);
                    end
                    "E": begin
                        void'($fscanf(fd, "%d %d %d", a, b, c));
                        repeat (c) sendCode(a[7:0], b[0]);
                    end
                    "S": begin
                        void'($fscanf(fd, "%d %d", a, b));
                        drive(16'h0000, 2'b00, 2'b00, 1'b1, a[7:0], b[0], 1'b0);
                        shadowSel[a[7:0]] = b[0];
                        idle(1);
                    end
                    "P": begin
                        void'($fscanf(fd, "%d %d %d", a, b, c));
                        repeat (c) popCheck(a[7:0], b);
                    end
                    "O": begin
                        void'($fscanf(fd, "%d", a));
                        idle(4); // last write lands three edges after its word
                        @(negedge evrClk);
                        checkBit("monOverflow_o", monOverflow, a[0]);
                    end
                    "Y": begin
                        void'($fscanf(fd, "%d", a));
                        idle(2);
                        @(negedge evrClk);
                        checkBit("monEmpty_o", monEmpty, a[0]);
                    end
                    "M": begin
                        void'($fscanf(fd, "%d %d %d", a, b, c));
                        markerPulse(a[7:0], b, c);
                    end
                    default: begin
                        noteError();
                        $display("unknown trace record %s", op);
                    end
                endcase
            end
        end
        closeTest();
    endtask

    ////////////////////////////////////////////////////////////
    // run and watchdog

    initial begin : runTrace
        int fd;
        rxData       <= '0;
        rxIsK        <= '0;
        rxNotInTable <= '0;
        monSelWe     <= 1'b0;
        monSelCode   <= '0;
        monSelOn     <= 1'b0;
        monReadEn    <= 1'b0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        testErrors  = 0;
        testName    = "";
        traceCycles = 0;
        idleCycles  = 0;
        tickBase    = -2; // first data word is seen two ticks after its drive edge
        shadowSel   = '0;
        void'($urandom(SEED));
        fd = $fopen("sim/evr_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the trace file sim/evr_trace.txt");
        end else begin
            runRecords(fd);
            $fclose(fd);
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (traceCycles > 0);
        while (cycleCnt <= 2 * traceCycles + idleCycles) @(posedge evrClk);
        $display("timeout: trace still running after %0d cycles", cycleCnt);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== sim/evr_trace.txt ====
# one record per line, opcode then decimal fields
# L cycles | T name | R | C commas | A aligned | N | K code | E code valid count
# S code on | P code seconds count | O overflow | Y empty | M code gap length | X
L 320
T reset
R
T alignment
E 20 0 1
C 59
A 0
C 1
A 1
N
A 0
C 60
A 1
T codeOutput
E 7 1 1
K 60
E 0 0 1
T monitor
S 7 1
S 9 1
E 7 1 1
E 8 1 1
E 9 1 1
E 125 1 1
E 9 1 1
P 7 0 1
P 9 0 1
P 9 1 1
Y 1
T overflow
E 7 1 9
O 1
P 7 1 8
Y 1
T markers
M 122 0 24
M 125 0 6
M 122 5 24
X

// ==== sim.f ====
+incdir+design
design/evrPkg.sv
design/evrLinkAlign.sv
design/evrTimeBase.sv
design/eventMonitorFifo.sv
design/evrMarkerStretch.sv
design/evrTop.sv
sim/evrClockGen.sv
sim/evrTop_tb.sv

// ==== Makefile ====
# Verilator build and run of the event receiver testbench

VERILATOR ?= verilator
TOP       ?= evrTop_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
